// ==== include/mem_defs.svh ====
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// RAM geometry
`define MEM_DEPTH 1024               // Words
`define MEM_WIDTH 32                 // Bits per word
`define MEM_LANES (`MEM_WIDTH / 8)   // Byte lanes per word

// Address widths, both derived from the geometry above
`define MEM_WADDR_W $clog2(`MEM_DEPTH)

// Byte address is the word address with the lane select bits below it
`define MEM_BADDR_W (`MEM_WADDR_W + $clog2(`MEM_LANES))

`endif

// ==== logic/data_port.sv ====
`default_nettype none

`include "mem_defs.svh"

module data_port
    import mem_pkg::*;
(
    input  wire                          g_clk,
    input  wire                          rst_n,

    // Master side, four-phase req/ack
    input  wire                          req,
    output logic                         ack,
    output logic                         err,        // Misaligned, valid with ack
    input  wire  [`MEM_BADDR_W-1:0]      addr,       // Byte address
    input  wire                          wen,
    input  var   access_size_t           size,
    input  wire                          sign_ext,   // Sign extend sub-word loads
    input  wire  [`MEM_WIDTH-1:0]        wdata,
    output mem_word_u                    rdata,

    // RAM side
    output logic                         ram_cen,
    output logic                         ram_wen,
    output logic [`MEM_LANES-1:0]        ram_strb,
    output logic [`MEM_WADDR_W-1:0]      ram_addr,   // Word address
    output logic [`MEM_WIDTH-1:0]        ram_wdata,
    input  wire  [`MEM_WIDTH-1:0]        ram_rdata
);

localparam logic [1:0] st_idle    = 2'd0;
localparam logic [1:0] st_issue   = 2'd1;  // RAM cycle in flight
localparam logic [1:0] st_release = 2'd2;  // Result out, wait for req low

logic [1:0]               state;
logic                     mis_q;           // Accepted access was misaligned

// Request captured on acceptance
logic                     wen_q;
access_size_t             size_q;
logic                     sign_q;
logic [1:0]               lane_q;          // Low byte address bits
logic [`MEM_LANES-1:0]    strb_q;
logic [`MEM_WADDR_W-1:0]  addr_q;
logic [`MEM_WIDTH-1:0]    wdata_q;

// Request decode
logic                     misaligned;
logic [`MEM_LANES-1:0]    strb_d;
logic [`MEM_WIDTH-1:0]    wdata_d;

// Load extraction
mem_word_u                ram_word;
mem_word_u                load_word;
logic [7:0]               load_b;
logic [15:0]              load_h;

// Alignment check, strobe select and lane replication
always_comb begin
    misaligned = 1'b0;
    strb_d     = '1;
    wdata_d    = wdata;
    case (size)
        size_byte: begin
            strb_d  = 4'b0001 << addr[1:0];
            wdata_d = {`MEM_LANES{wdata[7:0]}};
        end
        size_half: begin
            misaligned = addr[0];
            strb_d     = 4'b0011 << {addr[1], 1'b0};
            wdata_d    = {(`MEM_LANES/2){wdata[15:0]}};
        end
        size_word: begin
            misaligned = |addr[1:0];
        end
        default: begin
            misaligned = 1'b1;   // Reserved size code, never reaches the RAM
        end
    endcase
end

assign ram_word = ram_rdata;

// Same RAM word picked apart by lane or by half, depending on size
always_comb begin
    load_b = ram_word.lanes[lane_q];
    load_h = ram_word.halves[lane_q[1]];
    case (size_q)
        size_byte: load_word = {{24{sign_q & load_b[7]}}, load_b};
        size_half: load_word = {{16{sign_q & load_h[15]}}, load_h};
        default:   load_word = ram_word;
    endcase
end

// Handshake FSM
always_ff @(posedge g_clk or negedge rst_n) begin
    if (!rst_n) begin
        state <= st_idle;
        mis_q <= 1'b0;
        ack   <= 1'b0;
        err   <= 1'b0;
    end else begin
        case (state)
            st_idle: begin
                if (req) begin
                    state <= st_issue;
                    mis_q <= misaligned;
                end
            end
            st_issue: begin
                state <= st_release;   // RAM samples the request at this edge
            end
            st_release: begin
                if (!ack) begin
                    ack <= 1'b1;
                    err <= mis_q;
                end else if (!req) begin
                    ack   <= 1'b0;
                    state <= st_idle;
                end
            end
            default: begin
                state <= st_idle;
            end
        endcase
    end
end

// Request payload and load result
always_ff @(posedge g_clk) begin
    if ((state == st_idle) && req) begin
        wen_q   <= wen;
        size_q  <= size;
        sign_q  <= sign_ext;
        lane_q  <= addr[1:0];
        strb_q  <= strb_d;
        addr_q  <= addr[`MEM_BADDR_W-1:2];
        wdata_q <= wdata_d;
    end

    // Stores and errors leave the previous result in place
    if ((state == st_release) && !ack && !wen_q && !mis_q) begin
        rdata <= load_word;
    end
end

assign ram_cen   = (state == st_issue) && !mis_q;
assign ram_wen   = wen_q;
assign ram_strb  = strb_q;
assign ram_addr  = addr_q;
assign ram_wdata = wdata_q;

// Master keeps req up from acceptance until it has seen ack
ap_req_held : assert property (
    @(posedge g_clk) disable iff (!rst_n)
    ((state != st_idle) && !ack) |-> req
) else $error("data_port: req dropped before ack");

// RAM cycle only for an aligned request with its lane strobed,
// one cycle long, result and ack two edges after it starts
ap_cen_issue : assert property (
    @(posedge g_clk) disable iff (!rst_n)
    ram_cen |-> (ram_strb[lane_q]
                 && !((size_q == size_half) && lane_q[0])
                 && !((size_q == size_word) && (lane_q != 2'b00)))
            ##1 (!ram_cen && (state == st_release)) ##1 ack
) else $error("data_port: ram_cen for a misaligned or unstrobed request");

endmodule

`default_nettype wire

// ==== logic/dual_ram.sv ====
`default_nettype none

`include "mem_defs.svh"

module dual_ram #(
    parameter int DEPTH = `MEM_DEPTH      // RAM depth in words
) (
    input  wire                          g_clk,

    // Port a
    input  wire                          a_cen,    // Access this cycle
    input  wire                          a_wen,    // Write when set, else read
    input  wire  [`MEM_LANES-1:0]        a_strb,   // Per-lane write enable
    input  wire  [`MEM_WIDTH-1:0]        a_wdata,
    input  wire  [$clog2(DEPTH)-1:0]     a_addr,   // Word address
    output logic [`MEM_WIDTH-1:0]        a_rdata,

    // Port b
    input  wire                          b_cen,
    input  wire                          b_wen,
    input  wire  [`MEM_LANES-1:0]        b_strb,
    input  wire  [`MEM_WIDTH-1:0]        b_wdata,
    input  wire  [$clog2(DEPTH)-1:0]     b_addr,
    output logic [`MEM_WIDTH-1:0]        b_rdata
);

localparam int lane_w = $clog2(`MEM_LANES);

// Storage kept as bytes, word w lane l sits at index {w, l}
logic [7:0] mem [DEPTH*`MEM_LANES];

// Reads and writes for both ports, one lane per loop pass.
// Nonblocking updates give read-old-data when the other port
// writes the same byte on the same edge
always_ff @(posedge g_clk) begin
    for (int i = 0; i < `MEM_LANES; i++) begin
        if (a_cen) begin
            a_rdata[8*i +: 8] <= mem[{a_addr, lane_w'(i)}];
        end
        if (b_cen) begin
            b_rdata[8*i +: 8] <= mem[{b_addr, lane_w'(i)}];
        end

        if (a_cen && a_wen && a_strb[i]) begin
            mem[{a_addr, lane_w'(i)}] <= a_wdata[8*i +: 8];
        end
        if (b_cen && b_wen && b_strb[i]) begin
            mem[{b_addr, lane_w'(i)}] <= b_wdata[8*i +: 8];
        end
    end
end

// Both ports writing one byte on the same edge has no defined winner
ap_no_write_collision : assert property (
    @(posedge g_clk)
    (a_cen && a_wen && b_cen && b_wen && (a_addr == b_addr)) |-> ((a_strb & b_strb) == '0)
) else $error("dual_ram: ports a and b write overlapping lanes of word %0h", a_addr);

endmodule

`default_nettype wire

// ==== logic/mem_pkg.sv ====
`default_nettype none

`include "mem_defs.svh"

package mem_pkg;

    // Load/store access size
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } access_size_t;

    // One RAM word, seen as byte lanes or as halfwords
    typedef union packed {
        logic [`MEM_LANES-1:0][7:0]      lanes;   // Lane 0 is the low byte
        logic [`MEM_LANES/2-1:0][15:0]   halves;  // Half 0 is the low half
    } mem_word_u;

endpackage

`default_nettype wire

// ==== logic/mem_subsys_top.sv ====
`default_nettype none

`include "mem_defs.svh"

module mem_subsys_top
    import mem_pkg::*;
(
    input  wire                          g_clk,
    input  wire                          rst_n,

    // Master a
    input  wire                          a_req,
    output logic                         a_ack,
    output logic                         a_err,
    input  wire  [`MEM_BADDR_W-1:0]      a_addr,
    input  wire                          a_wen,
    input  var   access_size_t           a_size,
    input  wire                          a_sign_ext,
    input  wire  [`MEM_WIDTH-1:0]        a_wdata,
    output mem_word_u                    a_rdata,

    // Master b
    input  wire                          b_req,
    output logic                         b_ack,
    output logic                         b_err,
    input  wire  [`MEM_BADDR_W-1:0]      b_addr,
    input  wire                          b_wen,
    input  var   access_size_t           b_size,
    input  wire                          b_sign_ext,
    input  wire  [`MEM_WIDTH-1:0]        b_wdata,
    output mem_word_u                    b_rdata
);

// Adapter a to RAM side a
logic                      ra_cen;
logic                      ra_wen;
logic [`MEM_LANES-1:0]     ra_strb;
logic [`MEM_WADDR_W-1:0]   ra_addr;
logic [`MEM_WIDTH-1:0]     ra_wdata;
logic [`MEM_WIDTH-1:0]     ra_rdata;

// Adapter b to RAM side b
logic                      rb_cen;
logic                      rb_wen;
logic [`MEM_LANES-1:0]     rb_strb;
logic [`MEM_WADDR_W-1:0]   rb_addr;
logic [`MEM_WIDTH-1:0]     rb_wdata;
logic [`MEM_WIDTH-1:0]     rb_rdata;

data_port port_a (
    .g_clk     (g_clk),
    .rst_n     (rst_n),
    .req       (a_req),
    .ack       (a_ack),
    .err       (a_err),
    .addr      (a_addr),
    .wen       (a_wen),
    .size      (a_size),
    .sign_ext  (a_sign_ext),
    .wdata     (a_wdata),
    .rdata     (a_rdata),
    .ram_cen   (ra_cen),
    .ram_wen   (ra_wen),
    .ram_strb  (ra_strb),
    .ram_addr  (ra_addr),
    .ram_wdata (ra_wdata),
    .ram_rdata (ra_rdata)
);

data_port port_b (
    .g_clk     (g_clk),
    .rst_n     (rst_n),
    .req       (b_req),
    .ack       (b_ack),
    .err       (b_err),
    .addr      (b_addr),
    .wen       (b_wen),
    .size      (b_size),
    .sign_ext  (b_sign_ext),
    .wdata     (b_wdata),
    .rdata     (b_rdata),
    .ram_cen   (rb_cen),
    .ram_wen   (rb_wen),
    .ram_strb  (rb_strb),
    .ram_addr  (rb_addr),
    .ram_wdata (rb_wdata),
    .ram_rdata (rb_rdata)
);

// Shared storage, one side per adapter
dual_ram #(
    .DEPTH (`MEM_DEPTH)
) ram0 (
    .g_clk   (g_clk),
    .a_cen   (ra_cen),
    .a_wen   (ra_wen),
    .a_strb  (ra_strb),
    .a_wdata (ra_wdata),
    .a_addr  (ra_addr),
    .a_rdata (ra_rdata),
    .b_cen   (rb_cen),
    .b_wen   (rb_wen),
    .b_strb  (rb_strb),
    .b_wdata (rb_wdata),
    .b_addr  (rb_addr),
    .b_rdata (rb_rdata)
);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the memory subsystem testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_mem_subsys \
    -o tb_mem_subsys

./obj_dir/tb_mem_subsys > "$log" 2>&1
cat "$log"

if grep -q "^Verification passed$" "$log"; then
    echo "run.sh: simulation reported success"
    exit 0
else
    echo "run.sh: simulation did not report success"
    exit 1
fi

// ==== src.f ====
+incdir+include
logic/mem_pkg.sv
logic/dual_ram.sv
logic/data_port.sv
logic/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

// ==== testbench/tb_mem_subsys.sv ====
`default_nettype none

`include "mem_defs.svh"

module tb_mem_subsys
    import mem_pkg::*;
();

localparam int half_words = `MEM_DEPTH / 2;
localparam int n_pairs    = 40;   // Word write then read, per port
localparam int n_sub_st   = 40;
localparam int n_sub_ld   = 60;
localparam int n_mis      = 20;
localparam int n_mixed    = 80;
localparam int n_final    = 60;
localparam int per_port   = half_words + 2*n_pairs + 2*n_sub_st + n_sub_ld
                          + 2*n_mis + n_mixed + n_final;
localparam int wd_cycles  = 2 * per_port * 10 + 100;
localparam int ack_cycles = 3;    // Req sampled at k, ack out at k+2
localparam int wait_limit = 16;

logic                      g_clk;
logic                      rst_n;
logic                      a_req;
logic                      a_ack;
logic                      a_err;
logic [`MEM_BADDR_W-1:0]   a_addr;
logic                      a_wen;
access_size_t              a_size;
logic                      a_sign_ext;
logic [`MEM_WIDTH-1:0]     a_wdata;
mem_word_u                 a_rdata;
logic                      b_req;
logic                      b_ack;
logic                      b_err;
logic [`MEM_BADDR_W-1:0]   b_addr;
logic                      b_wen;
access_size_t              b_size;
logic                      b_sign_ext;
logic [`MEM_WIDTH-1:0]     b_wdata;
mem_word_u                 b_rdata;

logic [7:0]  model [`MEM_DEPTH*`MEM_LANES];   // Byte image of the RAM
mem_word_u   exp_rdata [2];                  // Last load result per port
logic        rdata_known [2];
integer      seed = 54;
int          errors = 0;
int          checks = 0;
int          timing_errors = 0;

mem_subsys_top dut0 (
    .g_clk(g_clk), .rst_n(rst_n),
    .a_req(a_req), .a_ack(a_ack), .a_err(a_err), .a_addr(a_addr), .a_wen(a_wen),
    .a_size(a_size), .a_sign_ext(a_sign_ext), .a_wdata(a_wdata), .a_rdata(a_rdata),
    .b_req(b_req), .b_ack(b_ack), .b_err(b_err), .b_addr(b_addr), .b_wen(b_wen),
    .b_size(b_size), .b_sign_ext(b_sign_ext), .b_wdata(b_wdata), .b_rdata(b_rdata)
);

initial g_clk = 1'b0;
always #50 g_clk = ~g_clk;

task automatic check_word(input string name, input mem_word_u exp, input mem_word_u act);
    checks++;
    if (act !== exp) begin
        $display("Fail at %0t: %s expected %08h, got %08h", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_err(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
        errors++;
    end
endtask

task automatic check_latency(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
        $display("Fail at %0t: %s expected %0d cycles, got %0d", $time, name, exp, act);
        errors++;
        timing_errors++;
    end
endtask

function automatic logic ack_of(input int p);
    return (p == 0) ? a_ack : b_ack;
endfunction

function automatic logic err_of(input int p);
    return (p == 0) ? a_err : b_err;
endfunction

function automatic mem_word_u rdata_of(input int p);
    return (p == 0) ? a_rdata : b_rdata;
endfunction

task automatic set_req(input int p, input logic v);
    if (p == 0) a_req = v;
    else        b_req = v;
endtask

task automatic set_inputs(input int p, input logic w, input access_size_t sz, input logic sx,
                          input logic [`MEM_BADDR_W-1:0] ad, input logic [31:0] wd);
    if (p == 0) begin
        a_wen      = w;
        a_size     = sz;
        a_sign_ext = sx;
        a_addr     = ad;
        a_wdata    = wd;
    end else begin
        b_wen      = w;
        b_size     = sz;
        b_sign_ext = sx;
        b_addr     = ad;
        b_wdata    = wd;
    end
endtask

function automatic logic [31:0] rnd();
    return $random(seed);
endfunction

function automatic access_size_t rand_size(input bit sub_only);
    logic [31:0] r;
    r = rnd();
    if (sub_only) begin
        return r[0] ? size_half : size_byte;
    end
    case (r % 3)
        0:       return size_byte;
        1:       return size_half;
        default: return size_word;
    endcase
endfunction

// Aligned byte address, top bit picks the port's half unless anywhere is set
function automatic logic [`MEM_BADDR_W-1:0] rand_addr(input int p, input access_size_t sz,
                                                      input bit anywhere);
    logic [31:0]             r;
    logic [`MEM_BADDR_W-1:0] ad;
    r  = rnd();
    ad = r[`MEM_BADDR_W-1:0];
    if (!anywhere) ad[`MEM_BADDR_W-1] = p[0];
    if (sz == size_half) ad[0] = 1'b0;
    if (sz == size_word) ad[1:0] = 2'b00;
    return ad;
endfunction

function automatic mem_word_u expected_load(input access_size_t sz, input logic sx,
                                            input logic [`MEM_BADDR_W-1:0] ad);
    logic [7:0]  b;
    logic [15:0] h;
    mem_word_u   w;
    b = model[ad];
    h = {model[{ad[`MEM_BADDR_W-1:1], 1'b1}], model[{ad[`MEM_BADDR_W-1:1], 1'b0}]};
    case (sz)
        size_byte: w = {{24{sx & b[7]}}, b};
        size_half: w = {{16{sx & h[15]}}, h};
        default:   w = {model[{ad[`MEM_BADDR_W-1:2], 2'd3}], model[{ad[`MEM_BADDR_W-1:2], 2'd2}],
                        model[{ad[`MEM_BADDR_W-1:2], 2'd1}], model[{ad[`MEM_BADDR_W-1:2], 2'd0}]};
    endcase
    return w;
endfunction

// Low byte or low half of wd lands in the addressed lanes
task automatic apply_store(input access_size_t sz, input logic [`MEM_BADDR_W-1:0] ad,
                           input logic [31:0] wd);
    case (sz)
        size_byte: model[ad] = wd[7:0];
        size_half: begin
            model[{ad[`MEM_BADDR_W-1:1], 1'b0}] = wd[7:0];
            model[{ad[`MEM_BADDR_W-1:1], 1'b1}] = wd[15:8];
        end
        default: begin
            for (int i = 0; i < `MEM_LANES; i++) begin
                model[{ad[`MEM_BADDR_W-1:2], 2'(i)}] = wd[8*i +: 8];
            end
        end
    endcase
endtask

// One four-phase transfer, checked against the model
task automatic access(input int p, input logic w, input access_size_t sz, input logic sx,
                      input logic [`MEM_BADDR_W-1:0] ad, input logic [31:0] wd);
    string     pn;
    logic      mis;
    logic      got;
    int        cyc;
    int        hold;
    mem_word_u exp_w;
    pn  = (p == 0) ? "a" : "b";
    mis = ((sz == size_half) && ad[0]) || ((sz == size_word) && (ad[1:0] != 2'b00));
    while (ack_of(p)) @(negedge g_clk);
    set_inputs(p, w, sz, sx, ad, wd);
    set_req(p, 1'b1);
    cyc = 0;
    got = 1'b0;
    while (!got && (cyc < wait_limit)) begin
        @(negedge g_clk);
        cyc++;
        got = ack_of(p);
    end
    if (!got) begin
        $display("Port %s got no ack within %0d cycles of req at %0t", pn, wait_limit, $time);
        errors++;
        timing_errors++;
        set_req(p, 1'b0);
        return;
    end
    check_latency({pn, "_ack"}, ack_cycles, cyc);
    check_err({pn, "_err"}, mis, err_of(p));
    if (!w && !mis) begin
        exp_w = expected_load(sz, sx, ad);
        check_word({pn, "_rdata"}, exp_w, rdata_of(p));
        exp_rdata[p]   = exp_w;
        rdata_known[p] = 1'b1;
    end else begin
        if (rdata_known[p]) check_word({pn, "_rdata"}, exp_rdata[p], rdata_of(p));
        if (w && !mis) apply_store(sz, ad, wd);
    end
    hold = $unsigned($random(seed)) % 4;   // Slow master holds req a while
    repeat (hold) @(negedge g_clk);
    set_req(p, 1'b0);
    cyc = 0;
    while (ack_of(p) && (cyc < wait_limit)) begin
        @(negedge g_clk);
        cyc++;
    end
    if (ack_of(p)) begin
        $display("Port %s kept ack high after req fell, at %0t", pn, $time);
        errors++;
        timing_errors++;
    end
endtask

task automatic run_phase(input int p, input int phase);
    logic [`MEM_BADDR_W-1:0] ad;
    access_size_t            sz;
    logic [31:0]             r;
    case (phase)
        0: for (int i = 0; i < half_words; i++) begin
            ad = {p[0], i[`MEM_WADDR_W-2:0], 2'b00};
            access(p, 1'b1, size_word, 1'b0, ad, rnd());
        end
        1: for (int i = 0; i < n_pairs; i++) begin
            ad = rand_addr(p, size_word, 1'b0);
            access(p, 1'b1, size_word, 1'b0, ad, rnd());
            access(p, 1'b0, size_word, 1'b0, ad, '0);
        end
        2: for (int i = 0; i < n_sub_st; i++) begin
            sz = rand_size(1'b1);
            ad = rand_addr(p, sz, 1'b0);
            access(p, 1'b1, sz, 1'b0, ad, rnd());
            access(p, 1'b0, size_word, 1'b0, {ad[`MEM_BADDR_W-1:2], 2'b00}, '0);
        end
        3: for (int i = 0; i < n_sub_ld; i++) begin
            sz = rand_size(1'b1);
            r  = rnd();
            access(p, 1'b0, sz, r[3], rand_addr(p, sz, 1'b0), '0);
        end
        4: for (int i = 0; i < n_mis; i++) begin
            r  = rnd();
            sz = r[0] ? size_half : size_word;
            ad = rand_addr(p, size_byte, 1'b0);
            if (sz == size_half) ad[0] = 1'b1;
            else if (ad[1:0] == 2'b00) ad[1:0] = 2'b10;
            access(p, r[1], sz, r[2], ad, rnd());
            access(p, 1'b0, size_word, 1'b0, {ad[`MEM_BADDR_W-1:2], 2'b00}, '0);
        end
        5: for (int i = 0; i < n_mixed; i++) begin
            sz = rand_size(1'b0);
            r  = rnd();
            access(p, r[0], sz, r[1], rand_addr(p, sz, 1'b0), rnd());
        end
        default: for (int i = 0; i < n_final; i++) begin
            sz = rand_size(1'b0);
            r  = rnd();
            access(p, 1'b0, sz, r[1], rand_addr(p, sz, 1'b1), '0);
        end
    endcase
endtask

task automatic run_both(input int phase);
    fork
        run_phase(0, phase);
        run_phase(1, phase);
    join
endtask

task automatic finish_test(input string name, input int errs_at_start);
    $display("Test %s: %s, %0d errors", name,
             (errors == errs_at_start) ? "ok" : "mismatches", errors - errs_at_start);
endtask

initial begin
    int start;
    rst_n = 1'b0;
    a_req = 1'b0;
    b_req = 1'b0;
    set_inputs(0, 1'b0, size_word, 1'b0, '0, '0);
    set_inputs(1, 1'b0, size_word, 1'b0, '0, '0);
    rdata_known[0] = 1'b0;
    rdata_known[1] = 1'b0;
    repeat (8) @(negedge g_clk);
    rst_n = 1'b1;

    start = errors;
    run_both(0);   // Fill so every byte is known to the model
    run_both(1);
    finish_test("word store and load", start);
    start = errors;
    run_both(2);
    finish_test("byte and halfword stores", start);
    start = errors;
    run_both(3);
    finish_test("sub-word loads", start);
    start = errors;
    run_both(4);
    finish_test("misaligned accesses", start);
    start = errors;
    run_both(5);
    $display("Test handshake timing: %s, %0d errors, %0d timing errors over the run",
             (errors == start) ? "ok" : "mismatches", errors - start, timing_errors);
    start = errors;
    run_both(6);
    finish_test("cross-port visibility", start);

    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
        $display("Verification passed");
    end else begin
        $display("Verification failed");
    end
    $finish;
end

initial begin
    repeat (wd_cycles) @(posedge g_clk);
    $display("Timeout: the tests did not finish within %0d cycles", wd_cycles);
    $display("Verification failed");
    $finish;
end

endmodule

`default_nettype wire
